//--- hdl/accel_pkg.sv
package accel_pkg;

  // one pixel or one weight
  localparam int word_width = 8;

  // 3x3 kernel, flattened
  localparam int taps = 9;

  // full product of two signed words
  localparam int prod_width = 2 * word_width;

  // nine 16-bit products summed, 4 extra bits of growth
  localparam int acc_width = 20;

  // leaky relu negative slope, 1/8
  localparam int lrelu_shift = 3;

  typedef logic signed [word_width-1:0] word_t;

  typedef logic signed [prod_width-1:0] prod_t;

  // tap 0 sits in the low byte
  typedef logic [taps*word_width-1:0] kernel_t;

  // same layout as the kernel, pixels instead of weights
  typedef logic [taps*word_width-1:0] window_t;

  // conv sum or activation
  typedef logic signed [acc_width-1:0] acc_t;

  // pixel beat, last marks the end of a row
  typedef struct packed {
    window_t window;
    logic    last;
  } pix_beat_t;

  // activation beat between the datapath stages
  typedef struct packed {
    acc_t data;
    logic last;
  } act_beat_t;

  // controller states
  typedef enum logic {
    load_kernel,
    run_row
  } ctrl_state_t;

endpackage

//--- hdl/accel_ctrl.sv
`timescale 1ns/1ps

module accel_ctrl (
  input  logic                  aclk,
  input  logic                  rst_n,
  // weight stream, one beat is a whole kernel
  input  logic                  w_valid,
  output logic                  w_ready,
  input  accel_pkg::kernel_t    w_kernel,
  // pixel stream from outside
  input  logic                  pix_valid,
  output logic                  pix_ready,
  input  accel_pkg::pix_beat_t  pix_beat,
  // windows towards the conv engine
  output logic                  conv_valid,
  input  logic                  conv_ready,
  output accel_pkg::pix_beat_t  conv_beat,
  output accel_pkg::kernel_t    kernel
);

  accel_pkg::ctrl_state_t state;
  logic                   w_fire;
  logic                   pix_fire;
  logic                   running;

  assign running = (state == accel_pkg::run_row);

  // weights only taken while waiting for a kernel
  assign w_ready = !running;
  assign w_fire  = w_valid && w_ready;

  // pixel path is combinational, gated by the state
  assign pix_ready  = running && conv_ready;
  assign conv_valid = running && pix_valid;
  assign conv_beat  = pix_beat;
  assign pix_fire   = pix_valid && pix_ready;

  // load/run sequencing
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= accel_pkg::load_kernel;
    end else begin
      case (state)
        accel_pkg::load_kernel: begin
          if (w_fire) begin
            state <= accel_pkg::run_row;
          end
        end
        accel_pkg::run_row: begin
          // end of row, next row needs a fresh kernel
          if (pix_fire && pix_beat.last) begin
            state <= accel_pkg::load_kernel;
          end
        end
        default: begin
          state <= accel_pkg::load_kernel;
        end
      endcase
    end
  end

  // kernel register, held for the whole row
  always_ff @(posedge aclk) begin
    if (w_fire) begin
      kernel <= w_kernel;
    end
  end

  // no pixels slip through while a kernel is pending
  a_no_pix_in_load: assert property (@(posedge aclk) disable iff (!rst_n)
    state == accel_pkg::load_kernel |-> !pix_ready);

endmodule

//--- hdl/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
  input  logic                  aclk,
  input  logic                  rst_n,
  // windows in
  input  logic                  s_valid,
  output logic                  s_ready,
  input  accel_pkg::pix_beat_t  s_beat,
  input  accel_pkg::kernel_t    kernel,
  // sums out
  output logic                  m_valid,
  input  logic                  m_ready,
  output accel_pkg::act_beat_t  m_beat
);

  // products of the incoming window, combinational
  accel_pkg::prod_t prod [accel_pkg::taps];

  // stage one, registered products
  accel_pkg::prod_t s1_prod [accel_pkg::taps];
  logic             s1_valid;
  logic             s1_last;
  logic             s1_ready;

  // stage two ready rule
  logic             s2_ready;

  accel_pkg::acc_t  sum;

  // one signed multiply per tap
  for (genvar i = 0; i < accel_pkg::taps; i++) begin : g_mul
    assign prod[i] =
      accel_pkg::word_t'(s_beat.window[i*accel_pkg::word_width +: accel_pkg::word_width]) *
      accel_pkg::word_t'(kernel[i*accel_pkg::word_width +: accel_pkg::word_width]);
  end

  // ready when empty or when the next stage drains us
  assign s2_ready = !m_valid || m_ready;
  assign s1_ready = !s1_valid || s2_ready;
  assign s_ready  = s1_ready;

  // sum of the nine registered products
  always_comb begin
    sum = '0;
    for (int i = 0; i < accel_pkg::taps; i++) begin
      // sign extend each product to the accumulator width
      sum = sum + accel_pkg::acc_t'(s1_prod[i]);
    end
  end

  // valid bits
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= s_valid;
      end
      if (s2_ready) begin
        m_valid <= s1_valid;
      end
    end
  end

  // stage one payload
  // products latched at accept time, so a kernel reload
  // cannot touch beats already in flight
  always_ff @(posedge aclk) begin
    if (s_valid && s1_ready) begin
      for (int i = 0; i < accel_pkg::taps; i++) begin
        s1_prod[i] <= prod[i];
      end
      s1_last <= s_beat.last;
    end
  end

  // stage two payload
  always_ff @(posedge aclk) begin
    if (s1_valid && s2_ready) begin
      m_beat.data <= sum;
      m_beat.last <= s1_last;
    end
  end

  // held beat must not change under back-pressure
  a_m_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

//--- hdl/lrelu_unit.sv
`timescale 1ns/1ps

module lrelu_unit (
  input  logic                  aclk,
  input  logic                  rst_n,
  // raw sums in
  input  logic                  s_valid,
  output logic                  s_ready,
  input  accel_pkg::act_beat_t  s_beat,
  // activations out
  output logic                  m_valid,
  input  logic                  m_ready,
  output accel_pkg::act_beat_t  m_beat
);

  accel_pkg::acc_t act;
  logic            s_fire;

  // negative side scaled by 1/8, rounds toward minus infinity
  assign act = s_beat.data[accel_pkg::acc_width-1] ?
               (s_beat.data >>> accel_pkg::lrelu_shift) : s_beat.data;

  // single register slot
  assign s_ready = !m_valid || m_ready;
  assign s_fire  = s_valid && s_ready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  // last travels with its data
  always_ff @(posedge aclk) begin
    if (s_fire) begin
      m_beat.data <= act;
      m_beat.last <= s_beat.last;
    end
  end

endmodule

//--- hdl/maxpool_unit.sv
`timescale 1ns/1ps

module maxpool_unit (
  input  logic                  aclk,
  input  logic                  rst_n,
  // activations in
  input  logic                  s_valid,
  output logic                  s_ready,
  input  accel_pkg::act_beat_t  s_beat,
  // pooled values out
  output logic                  m_valid,
  input  logic                  m_ready,
  output accel_pkg::act_beat_t  m_beat
);

  // first element of the open pair
  accel_pkg::acc_t first_data;
  logic            have_first;

  logic            s_fire;
  logic            pair_done;
  accel_pkg::acc_t pool_max;

  assign s_ready = !m_valid || m_ready;
  assign s_fire  = s_valid && s_ready;

  // second of a pair, or a lone first that ends the row
  assign pair_done = have_first || s_beat.last;

  // signed max, a lone element passes as is
  assign pool_max = (have_first && (first_data > s_beat.data)) ? first_data : s_beat.data;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      have_first <= 1'b0;
    end else begin
      if (s_ready) begin
        m_valid <= s_fire && pair_done;
      end
      if (s_fire) begin
        have_first <= !pair_done;
      end
    end
  end

  // pair storage and output register
  always_ff @(posedge aclk) begin
    if (s_fire && !pair_done) begin
      first_data <= s_beat.data;
    end
    if (s_fire && pair_done) begin
      m_beat.data <= pool_max;
      // last always comes from the closing element
      m_beat.last <= s_beat.last;
    end
  end

  a_out_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_beat));

  // pairs never straddle two rows
  a_pair_closed: assert property (@(posedge aclk) disable iff (!rst_n)
    s_fire && s_beat.last |=> !have_first);

endmodule

//--- hdl/accel_top.sv
`timescale 1ns/1ps

module accel_top (
  input  logic                  aclk,
  input  logic                  rst_n,
  // kernel in
  input  logic                  w_valid,
  output logic                  w_ready,
  input  accel_pkg::kernel_t    w_kernel,
  // windows in
  input  logic                  pix_valid,
  output logic                  pix_ready,
  input  accel_pkg::pix_beat_t  pix_beat,
  // pooled activations out
  output logic                  out_valid,
  input  logic                  out_ready,
  output accel_pkg::act_beat_t  out_beat
);

  // controller to conv engine
  logic                 conv_valid;
  logic                 conv_ready;
  accel_pkg::pix_beat_t conv_beat;
  accel_pkg::kernel_t   kernel;

  // conv engine to leaky relu
  logic                 mac_valid;
  logic                 mac_ready;
  accel_pkg::act_beat_t mac_beat;

  // leaky relu to max-pool
  logic                 act_valid;
  logic                 act_ready;
  accel_pkg::act_beat_t act_beat;

  accel_ctrl ctrl (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_kernel   (w_kernel),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_beat   (pix_beat),
    .conv_valid (conv_valid),
    .conv_ready (conv_ready),
    .conv_beat  (conv_beat),
    .kernel     (kernel)
  );

  // window x kernel, two stages
  conv_mac mac (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (conv_valid),
    .s_ready (conv_ready),
    .s_beat  (conv_beat),
    .kernel  (kernel),
    .m_valid (mac_valid),
    .m_ready (mac_ready),
    .m_beat  (mac_beat)
  );

  lrelu_unit lrelu (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (mac_valid),
    .s_ready (mac_ready),
    .s_beat  (mac_beat),
    .m_valid (act_valid),
    .m_ready (act_ready),
    .m_beat  (act_beat)
  );

  // 1x2 pooling drives the top output
  maxpool_unit pool (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (act_valid),
    .s_ready (act_ready),
    .s_beat  (act_beat),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_beat  (out_beat)
  );

endmodule

//--- testbench/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;

  logic                 aclk;
  logic                 rst_n;
  logic                 w_valid;
  logic                 w_ready;
  accel_pkg::kernel_t   w_kernel;
  logic                 pix_valid;
  logic                 pix_ready;
  accel_pkg::pix_beat_t pix_beat;
  logic                 out_valid;
  logic                 out_ready;
  accel_pkg::act_beat_t out_beat;

  // parsed case file, K and P lines kept in file order
  logic                 op_is_pix [$];
  accel_pkg::pix_beat_t op_beat [$];
  accel_pkg::act_beat_t exp_all [$];
  string                t_name [$];
  logic                 t_bp [$];
  int                   t_op_end [$];
  int                   t_exp_end [$];

  // expected pooled beats of the running test
  accel_pkg::act_beat_t sb_q [$];
  int                   err_count;
  int                   pass_count;
  int                   fail_count;
  int                   n_pix;
  int                   cycles;
  int                   cycle_limit;
  logic                 bp_on;

  accel_top uut (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w_kernel  (w_kernel),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .pix_beat  (pix_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  // 20 ns clock
  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // run limit, 40 cycles per pixel beat plus setup
  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles", cycles);
    $display("=== FAIL ===");
    $finish;
  end

  // random sink stalls only in back-pressure tests
  initial begin
    // fixed stall pattern for every run
    void'($urandom(32'h6c00));
    forever begin
      @(posedge aclk);
      #2;
      out_ready = bp_on ? ($urandom % 2 == 1) : 1'b1;
    end
  end

  // every output transfer against the scoreboard head, sampled mid-cycle
  initial begin
    accel_pkg::act_beat_t head;
    forever begin
      @(negedge aclk);
      if (rst_n && out_valid && out_ready) begin
        if (sb_q.size() == 0) begin
          $display("output %h arrived with no expected value pending", out_beat.data);
          err_count++;
        end else begin
          head = sb_q.pop_front();
          if (out_beat.data !== head.data) begin
            $display("MISMATCH out_beat.data expected %h got %h", head.data, out_beat.data);
            err_count++;
          end
          if (out_beat.last !== head.last) begin
            $display("MISMATCH out_beat.last expected %h got %h", head.last, out_beat.last);
            err_count++;
          end
        end
      end
    end
  end

  task automatic check_flag(input string sig, input logic exp, input logic got);
    if (got !== exp) begin
      $display("MISMATCH %s expected %h got %h", sig, exp, got);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %s ok", name);
      pass_count++;
    end else begin
      $display("test %s failed with %0d errors", name, err_count - errs_before);
      fail_count++;
    end
  endtask

  // marks where the open test ends in the op and expect lists
  task automatic close_test();
    if (t_name.size() > t_op_end.size()) begin
      t_op_end.push_back(op_is_pix.size());
      t_exp_end.push_back(exp_all.size());
    end
  endtask

  task automatic load_cases();
    int                   fd;
    int                   n;
    int                   v [10];
    logic [8*128-1:0]     line;
    logic [7:0]           tag;
    logic [8*24-1:0]      name;
    accel_pkg::pix_beat_t beat;
    accel_pkg::act_beat_t exp_beat;
    fd = $fopen("testbench/accel_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/accel_cases.txt");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        tag = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%s", tag);
        if (tag == "T") begin
          close_test();
          n = $sscanf(line, "%s %s %d", tag, name, v[0]);
          t_name.push_back($sformatf("%0s", name));
          t_bp.push_back(v[0] != 0);
        end else if (tag == "K" || tag == "P") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", tag, v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
          // K has nine weights, P has last then nine pixels
          for (int i = 0; i < accel_pkg::taps; i++) begin
            beat.window[i*accel_pkg::word_width +: accel_pkg::word_width] =
              accel_pkg::word_t'((tag == "K") ? v[i] : v[i+1]);
          end
          beat.last = (tag == "P") && (v[0] != 0);
          op_is_pix.push_back(tag == "P");
          op_beat.push_back(beat);
          if (tag == "P") begin
            n_pix++;
          end
        end else if (tag == "E") begin
          n = $sscanf(line, "%s %d %d", tag, v[0], v[1]);
          exp_beat.data = accel_pkg::acc_t'(v[0]);
          exp_beat.last = (v[1] != 0);
          exp_all.push_back(exp_beat);
        end
      end
      close_test();
      $fclose(fd);
      if (t_name.size() == 0) begin
        $display("no tests found in the case file");
        fail_count++;
      end
    end
  endtask

  // one kernel beat, the pixel gate must stay shut meanwhile
  task automatic send_kernel(input accel_pkg::kernel_t k);
    logic done;
    w_valid = 1'b1;
    w_kernel = k;
    done = 1'b0;
    while (!done) begin
      @(negedge aclk);
      done = w_ready;
      check_flag("pix_ready", 1'b0, pix_ready);
      @(posedge aclk);
      #2;
    end
    w_valid = 1'b0;
  endtask

  task automatic send_pixel(input accel_pkg::pix_beat_t b);
    logic done;
    pix_valid = 1'b1;
    pix_beat = b;
    done = 1'b0;
    while (!done) begin
      @(negedge aclk);
      done = pix_ready;
      @(posedge aclk);
      #2;
    end
    pix_valid = 1'b0;
    // row end sends the controller back to kernel loading
    if (b.last) begin
      check_flag("pix_ready", 1'b0, pix_ready);
      check_flag("w_ready", 1'b1, w_ready);
    end
  endtask

  task automatic check_reset();
    int errs;
    errs = err_count;
    check_flag("w_ready", 1'b1, w_ready);
    check_flag("pix_ready", 1'b0, pix_ready);
    check_flag("out_valid", 1'b0, out_valid);
    // windows offered with no kernel loaded yet
    pix_valid = 1'b1;
    pix_beat = '1;
    repeat (4) begin
      @(negedge aclk);
      if (pix_ready !== 1'b0) begin
        $display("pix_ready went high before any kernel was loaded");
        err_count++;
      end
    end
    @(posedge aclk);
    #2;
    pix_valid = 1'b0;
    report_test("reset_state", errs);
  endtask

  task automatic run_test(input int t);
    int errs;
    int first_op;
    int first_exp;
    int wait_cycles;
    errs = err_count;
    first_op = (t == 0) ? 0 : t_op_end[t-1];
    first_exp = (t == 0) ? 0 : t_exp_end[t-1];
    for (int i = first_exp; i < t_exp_end[t]; i++) begin
      sb_q.push_back(exp_all[i]);
    end
    bp_on = t_bp[t];
    for (int i = first_op; i < t_op_end[t]; i++) begin
      if (op_is_pix[i]) begin
        send_pixel(op_beat[i]);
      end else begin
        send_kernel(op_beat[i].window);
      end
    end
    // drain the pipeline
    wait_cycles = 0;
    while (sb_q.size() > 0 && wait_cycles < 100) begin
      @(posedge aclk);
      #2;
      wait_cycles++;
    end
    if (sb_q.size() > 0) begin
      $display("%0d expected outputs never arrived", sb_q.size());
      err_count++;
      sb_q.delete();
    end
    bp_on = 1'b0;
    // quiet gap, any extra output shows up here
    repeat (8) @(posedge aclk);
    #2;
    report_test(t_name[t], errs);
  endtask

  initial begin
    rst_n = 1'b0;
    w_valid = 1'b0;
    w_kernel = '0;
    pix_valid = 1'b0;
    pix_beat = '0;
    out_ready = 1'b1;
    bp_on = 1'b0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    n_pix = 0;
    load_cases();
    cycle_limit = 40 * n_pix + 200;
    repeat (5) @(posedge aclk);
    #2;
    rst_n = 1'b1;
    check_reset();
    for (int t = 0; t < t_name.size(); t++) begin
      run_test(t);
    end
    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- testbench/accel_cases.txt
# T name backpressure | K w0..w8 | P last p0..p8 | E pooled last (tap 0 first, signed)
T conv_lrelu 0
K 1 -1 2 0 3 0 -2 1 1
P 0 -10 5 7 1 -4 2 3 6 -9
P 0 -128 127 -128 50 127 -1 127 -128 -128
P 0 100 -50 25 9 20 8 -30 40 10
P 1 0 100 0 0 0 0 0 0 0
E -3 0
E 370 1
T reload_odd 0
K 2 2 2 2 2 2 2 2 2
P 0 1 2 3 4 5 6 7 8 9
P 1 -1 -1 -1 -1 -1 -1 -1 -1 10
K -3 1 0 0 4 0 0 -1 2
P 0 1 2 3 4 5 6 7 8 9
P 0 10 -10 5 5 5 5 5 5 -5
P 1 20 0 0 0 -7 0 0 0 0
E 90 1
E 29 0
E -11 1
T backpressure 1
K 4 -4 3 -3 2 -2 1 -1 5
P 0 10 10 10 10 10 10 10 10 10
P 0 -8 8 0 0 0 0 0 0 0
P 0 0 0 0 0 0 0 0 0 -25
P 1 0 0 0 0 0 0 0 0 -24
E 50 0
E -15 1

//--- tb.f
hdl/accel_pkg.sv
hdl/accel_ctrl.sv
hdl/conv_mac.sv
hdl/lrelu_unit.sv
hdl/maxpool_unit.sv
hdl/accel_top.sv
testbench/tb_accel.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_DIR    ?= obj_dir
SEED_FLAGS ?=
LOG        ?= sim.log
TOP        := tb_accel
FILELIST   := tb.f
SOURCES    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN    := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SEED_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(SIM_DIR) $(LOG)
